/* adc_params.svh */
`ifndef ADC_PARAMS_SVH
`define ADC_PARAMS_SVH

// converter slave address on the bus
`define ADC_I2C_ADDR 7'h48

// longest transaction is the three byte configuration write
`define I2C_MAX_BYTES 3

// clk cycles per quarter SCL period, 10 MHz / (4 * 25) = 100 kHz
`define I2C_QUARTER_DIV 25

// clk cycles from one transaction start to the next
`define SAMPLE_PERIOD 6000

// entries kept in the sample ring
`define SAMPLE_DEPTH 10

// level LED thresholds on the raw 16-bit result
`define LED_HIGH_LEVEL 49152
`define LED_MID_LEVEL 32768

`endif

/* adc_pkg.sv */
package adc_pkg;

	typedef logic [7:0]  i2c_byte_t;     // one bus byte
	typedef logic [6:0]  i2c_addr_t;     // 7-bit slave address
	typedef logic [1:0]  byte_count_t;   // 1 to 3 bytes
	typedef logic [15:0] adc_sample_t;   // first byte read is the upper half
	typedef logic [3:0]  sample_idx_t;
	typedef logic [3:0]  sample_count_t; // 0 to 10

	typedef enum logic [1:0] {
		SEQ_CONFIG,
		SEQ_SET_PTR,
		SEQ_SAMPLE,
		SEQ_WAIT
	} seq_state_t;

	typedef enum logic [3:0] {
		M_IDLE,
		M_START,
		M_ADDR,
		M_ADDR_ACK,
		M_WR_BYTE,
		M_WR_ACK,
		M_RD_BYTE,
		M_RD_ACK,
		M_STOP
	} master_state_t;

endpackage

/* i2c_cmd_if.sv */
`timescale 1ns/10ps
`include "adc_params.svh"

interface i2c_cmd_if;
	import adc_pkg::*;

	logic        start;    // one-cycle request strobe
	logic        rd_nwr;
	i2c_addr_t   addr;
	i2c_byte_t   wr_bytes [0:`I2C_MAX_BYTES-1];
	byte_count_t byte_num;
	i2c_byte_t   rd_bytes [0:`I2C_MAX_BYTES-1]; // held until next start
	logic        done;     // one cycle after stop
	logic        error;    // a missing acknowledge in the last transaction

	modport initiator (
		output start,
		output rd_nwr,
		output addr,
		output wr_bytes,
		output byte_num,
		input  rd_bytes,
		input  done,
		input  error
	);

	modport target (
		input  start,
		input  rd_nwr,
		input  addr,
		input  wr_bytes,
		input  byte_num,
		output rd_bytes,
		output done,
		output error
	);

endinterface

/* i2c_master.sv */
`timescale 1ns/10ps
`include "adc_params.svh"

module i2c_master (
	input  logic         clk,
	input  logic         reset,
	input  logic         scl_in,
	input  logic         sda_in,
	output logic         scl_oe,
	output logic         sda_oe,
	i2c_cmd_if.target    cmd
);
	import adc_pkg::*;

	localparam int DIV_W = $clog2(`I2C_QUARTER_DIV);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`I2C_QUARTER_DIV - 1);

	master_state_t    state;
	logic [DIV_W-1:0] div_cnt;
	logic [1:0]       quarter;    // 0,1 SCL low, 2,3 SCL high
	logic             tick;       // end of a quarter
	logic             hold_start;
	logic             bus_free;
	logic [2:0]       bit_cnt;
	byte_count_t      byte_idx;
	logic             last_byte;
	logic             nack_seen;
	logic             sda_drive;

	// request copy and shifter
	logic             rd_nwr_q;
	byte_count_t      byte_num_q;
	i2c_byte_t        wr_q [0:`I2C_MAX_BYTES-1];
	i2c_byte_t        shift_reg;

	assign bus_free   = scl_in & sda_in;
	assign hold_start = (state == M_START) && (quarter == 2'd0) && !bus_free; // wait for idle bus
	assign tick       = (state != M_IDLE) && (div_cnt == DIV_LAST);
	assign last_byte  = (byte_idx == byte_num_q - 2'd1);

	// open drain, 1 pulls the line low
	assign scl_oe = (state != M_IDLE) && (state != M_START) && !quarter[1];
	assign sda_oe = sda_drive;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state     <= M_IDLE;
			div_cnt   <= '0;
			quarter   <= 2'd0;
			bit_cnt   <= 3'd0;
			byte_idx  <= '0;
			nack_seen <= 1'b0;
			sda_drive <= 1'b0;
			cmd.done  <= 1'b0;
			cmd.error <= 1'b0;
		end else begin
			cmd.done <= 1'b0;

			if (state == M_IDLE || hold_start || tick)
				div_cnt <= '0;
			else
				div_cnt <= div_cnt + 1'b1;

			if (state == M_IDLE) begin
				quarter   <= 2'd0;
				sda_drive <= 1'b0;
				if (cmd.start) begin
					state     <= M_START;
					nack_seen <= 1'b0;
					byte_idx  <= '0;
					bit_cnt   <= 3'd0;
				end
			end else if (tick) begin
				quarter <= quarter + 2'd1;
				case (quarter)
					2'd0: begin // middle of SCL low, SDA may change
						case (state)
							M_ADDR, M_WR_BYTE: sda_drive <= ~shift_reg[7];
							M_RD_ACK:          sda_drive <= ~last_byte; // NACK on last byte
							M_STOP:            sda_drive <= 1'b1;
							default:           sda_drive <= 1'b0;
						endcase
					end
					2'd1: begin
						if (state == M_START)
							sda_drive <= 1'b1; // SDA falls while SCL high
					end
					2'd2: begin // SCL high midpoint
						if ((state == M_ADDR_ACK || state == M_WR_ACK) && sda_in)
							nack_seen <= 1'b1;
						if (state == M_STOP)
							sda_drive <= 1'b0; // SDA rises while SCL high
					end
					default: begin // end of bit period
						case (state)
							M_START: state <= M_ADDR;
							M_ADDR: begin
								bit_cnt <= bit_cnt + 3'd1;
								if (bit_cnt == 3'd7)
									state <= M_ADDR_ACK;
							end
							M_WR_BYTE: begin
								bit_cnt <= bit_cnt + 3'd1;
								if (bit_cnt == 3'd7)
									state <= M_WR_ACK;
							end
							M_RD_BYTE: begin
								bit_cnt <= bit_cnt + 3'd1;
								if (bit_cnt == 3'd7)
									state <= M_RD_ACK;
							end
							M_ADDR_ACK: begin
								if (nack_seen)
									state <= M_STOP;
								else if (rd_nwr_q)
									state <= M_RD_BYTE;
								else
									state <= M_WR_BYTE;
							end
							M_WR_ACK: begin
								if (nack_seen || last_byte) begin
									state <= M_STOP; // skip remaining bytes on NACK
								end else begin
									byte_idx <= byte_idx + 2'd1;
									state    <= M_WR_BYTE;
								end
							end
							M_RD_ACK: begin
								if (last_byte) begin
									state <= M_STOP;
								end else begin
									byte_idx <= byte_idx + 2'd1;
									state    <= M_RD_BYTE;
								end
							end
							M_STOP: begin
								state     <= M_IDLE;
								cmd.done  <= 1'b1;
								cmd.error <= nack_seen;
							end
							default: state <= M_IDLE;
						endcase
					end
				endcase
			end
		end
	end

	// data path, no reset
	always_ff @(posedge clk) begin
		if (state == M_IDLE && cmd.start) begin
			rd_nwr_q   <= cmd.rd_nwr;
			byte_num_q <= cmd.byte_num;
			wr_q       <= cmd.wr_bytes;
			shift_reg  <= {cmd.addr, cmd.rd_nwr};
		end else if (tick) begin
			case (state)
				M_ADDR, M_WR_BYTE: begin
					if (quarter == 2'd3)
						shift_reg <= {shift_reg[6:0], 1'b0}; // MSB first
				end
				M_ADDR_ACK: begin
					if (quarter == 2'd3)
						shift_reg <= wr_q[0];
				end
				M_WR_ACK: begin
					if (quarter == 2'd3 && !last_byte)
						shift_reg <= wr_q[byte_idx + 2'd1];
				end
				M_RD_BYTE: begin
					if (quarter == 2'd2)
						shift_reg <= {shift_reg[6:0], sda_in};
					if (quarter == 2'd3 && bit_cnt == 3'd7)
						cmd.rd_bytes[byte_idx] <= shift_reg;
				end
				default: ;
			endcase
		end
	end

endmodule

/* adc_sequencer.sv */
`timescale 1ns/10ps
`include "adc_params.svh"

module adc_sequencer (
	input  logic                 clk,
	input  logic                 reset,
	i2c_cmd_if.initiator         cmd,
	output logic                 sample_valid,
	output adc_pkg::adc_sample_t sample
);
	import adc_pkg::*;

	localparam int WAIT_W = $clog2(`SAMPLE_PERIOD);
	// reached PERIOD-1 cycles after start, so the next start lands on PERIOD
	localparam logic [WAIT_W-1:0] WAIT_LAST = WAIT_W'(`SAMPLE_PERIOD - 2);

	seq_state_t        state;
	seq_state_t        next_state; // where the wait goes after a good done
	logic [WAIT_W-1:0] wait_cnt;
	logic              done_seen;
	logic              err_seen;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state        <= SEQ_CONFIG;
			next_state   <= SEQ_SET_PTR;
			wait_cnt     <= '0;
			done_seen    <= 1'b0;
			err_seen     <= 1'b0;
			cmd.start    <= 1'b0;
			sample_valid <= 1'b0;
		end else begin
			cmd.start    <= 1'b0;
			sample_valid <= 1'b0;

			if (state != SEQ_WAIT) begin
				cmd.start <= 1'b1; // request fields load on the same edge
				wait_cnt  <= '0;
				done_seen <= 1'b0;
				state     <= SEQ_WAIT;
			end

			case (state)
				SEQ_CONFIG:  next_state <= SEQ_SET_PTR;
				SEQ_SET_PTR: next_state <= SEQ_SAMPLE;
				SEQ_SAMPLE:  next_state <= SEQ_SAMPLE;
				default: begin
					if (wait_cnt != WAIT_LAST)
						wait_cnt <= wait_cnt + 1'b1;
					if (cmd.done) begin
						done_seen    <= 1'b1;
						err_seen     <= cmd.error;
						sample_valid <= cmd.rd_nwr & ~cmd.error;
					end
					if (done_seen && wait_cnt == WAIT_LAST)
						state <= err_seen ? SEQ_CONFIG : next_state; // reconfigure after NACK
				end
			endcase
		end
	end

	// request fields and sample data
	always_ff @(posedge clk) begin
		if (cmd.done)
			sample <= {cmd.rd_bytes[0], cmd.rd_bytes[1]};

		if (state != SEQ_WAIT) begin
			cmd.addr <= `ADC_I2C_ADDR;
			case (state)
				SEQ_CONFIG: begin
					cmd.rd_nwr   <= 1'b0;
					cmd.wr_bytes <= '{8'h01, 8'h42, 8'h83}; // pointer, config msb, config lsb
					cmd.byte_num <= 2'd3;
				end
				SEQ_SET_PTR: begin
					cmd.rd_nwr   <= 1'b0;
					cmd.wr_bytes <= '{8'h00, 8'h00, 8'h00}; // conversion register
					cmd.byte_num <= 2'd1;
				end
				default: begin
					cmd.rd_nwr   <= 1'b1;
					cmd.byte_num <= 2'd2;
				end
			endcase
		end
	end

endmodule

/* adc_sample_regs.sv */
`timescale 1ns/10ps
`include "adc_params.svh"

module adc_sample_regs (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   sample_valid,
	input  adc_pkg::adc_sample_t   sample,
	input  adc_pkg::sample_idx_t   sample_rd_idx,
	input  logic                   cmd_error,
	output adc_pkg::adc_sample_t   sample_rd_data,
	output adc_pkg::sample_count_t sample_count,
	output logic                   led1,
	output logic                   led2,
	output logic                   led3,
	output logic                   led4
);
	import adc_pkg::*;

	localparam sample_idx_t   LAST_IDX   = sample_idx_t'(`SAMPLE_DEPTH - 1);
	localparam sample_count_t FULL_COUNT = sample_count_t'(`SAMPLE_DEPTH);
	localparam adc_sample_t   HIGH_LEVEL = adc_sample_t'(`LED_HIGH_LEVEL);
	localparam adc_sample_t   MID_LEVEL  = adc_sample_t'(`LED_MID_LEVEL);

	adc_sample_t ring [0:`SAMPLE_DEPTH-1];
	sample_idx_t wr_idx; // next slot, oldest once full

	always_ff @(posedge clk) begin
		if (sample_valid)
			ring[wr_idx] <= sample;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wr_idx       <= '0;
			sample_count <= '0;
			led1         <= 1'b0;
			led2         <= 1'b0;
			led3         <= 1'b0;
			led4         <= 1'b0;
		end else begin
			led4 <= cmd_error; // level from the latest done
			if (sample_valid) begin
				wr_idx <= (wr_idx == LAST_IDX) ? '0 : wr_idx + 1'b1;
				if (sample_count != FULL_COUNT)
					sample_count <= sample_count + 1'b1;
				led3 <= (sample > HIGH_LEVEL);
				led2 <= (sample <= HIGH_LEVEL) && (sample > MID_LEVEL);
				led1 <= (sample <= MID_LEVEL);
			end
		end
	end

	// out-of-range index reads zero
	assign sample_rd_data = (sample_rd_idx <= LAST_IDX) ? ring[sample_rd_idx] : '0;

endmodule

/* adc_monitor_top.sv */
`timescale 1ns/10ps

module adc_monitor_top (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   scl_in,
	input  logic                   sda_in,
	input  adc_pkg::sample_idx_t   sample_rd_idx,
	output logic                   scl_oe,
	output logic                   sda_oe,
	output adc_pkg::adc_sample_t   sample_rd_data,
	output adc_pkg::sample_count_t sample_count,
	output logic                   led1,
	output logic                   led2,
	output logic                   led3,
	output logic                   led4
);
	import adc_pkg::*;

	logic        sample_valid;
	adc_sample_t sample;

	i2c_cmd_if cmd_bus ();

	i2c_master u_master (
		.clk    (clk),
		.reset  (reset),
		.scl_in (scl_in),
		.sda_in (sda_in),
		.scl_oe (scl_oe),
		.sda_oe (sda_oe),
		.cmd    (cmd_bus)
	);

	adc_sequencer u_sequencer (
		.clk          (clk),
		.reset        (reset),
		.cmd          (cmd_bus),
		.sample_valid (sample_valid),
		.sample       (sample)
	);

	adc_sample_regs u_sample_regs (
		.clk            (clk),
		.reset          (reset),
		.sample_valid   (sample_valid),
		.sample         (sample),
		.sample_rd_idx  (sample_rd_idx),
		.cmd_error      (cmd_bus.error),
		.sample_rd_data (sample_rd_data),
		.sample_count   (sample_count),
		.led1           (led1),
		.led2           (led2),
		.led3           (led3),
		.led4           (led4)
	);

endmodule

/* i2c_adc_model.sv */
`timescale 1ns/10ps
`include "adc_params.svh"

module i2c_adc_model (
	input  logic clk,
	input  logic scl,
	input  logic sda,
	input  logic nack_all,
	output logic sda_oe
);
	import adc_pkg::*;

	typedef enum logic [1:0] {PH_IDLE, PH_ADDR, PH_WRITE, PH_READ} phase_t;

	phase_t      phase = PH_IDLE;
	logic        scl_q = 1'b1;
	logic        sda_q = 1'b1;
	int          bit_cnt = 0;    // SCL rises in the current 9-bit frame
	i2c_byte_t   shreg;
	i2c_byte_t   addr_byte;      // address with the direction bit
	logic        acked = 1'b0;
	logic        master_ack = 1'b0;
	int          n_bytes = 0;
	logic [23:0] wr_data;        // byte k at [8k+7:8k]
	i2c_byte_t   rd_q [$];
	int          reads_done = 0;
	int          underruns = 0;

	// one entry per write transaction, acknowledged or not
	i2c_byte_t   log_addr [$];
	logic        log_ack [$];
	int          log_len [$];
	logic [23:0] log_data [$];

	initial sda_oe = 1'b0;

	task automatic queue_read(input i2c_byte_t b);
		rd_q.push_back(b);
	endtask

	function automatic int log_size();
		return log_len.size();
	endfunction

	task automatic read_log(input int idx, output i2c_byte_t a, output logic ack,
			output int len, output logic [23:0] data);
		a    = log_addr[idx];
		ack  = log_ack[idx];
		len  = log_len[idx];
		data = log_data[idx];
	endtask

	always @(posedge clk) begin
		i2c_byte_t nb;
		scl_q <= scl;
		sda_q <= sda;
		if (scl && scl_q && sda_q && !sda) begin // start condition
			phase   <= PH_ADDR;
			bit_cnt <= 0;
			n_bytes <= 0;
			wr_data <= '0;
		end else if (scl && scl_q && !sda_q && sda) begin // stop condition
			if (phase != PH_IDLE && !addr_byte[0]) begin
				log_addr.push_back(addr_byte);
				log_ack.push_back(acked);
				log_len.push_back(n_bytes);
				log_data.push_back(wr_data);
			end
			if (phase != PH_IDLE && acked && addr_byte[0])
				reads_done <= reads_done + 1;
			phase  <= PH_IDLE;
			sda_oe <= 1'b0;
		end else if (phase != PH_IDLE && scl && !scl_q) begin
			bit_cnt <= bit_cnt + 1;
			if (phase != PH_READ)
				shreg <= {shreg[6:0], sda};
			else if (bit_cnt == 8)
				master_ack <= !sda;
		end else if (phase != PH_IDLE && !scl && scl_q) begin
			if (bit_cnt == 8) begin
				case (phase)
					PH_ADDR: begin
						addr_byte <= shreg;
						acked     <= (shreg[7:1] == `ADC_I2C_ADDR) && !nack_all;
						sda_oe    <= (shreg[7:1] == `ADC_I2C_ADDR) && !nack_all;
					end
					PH_WRITE: begin
						wr_data[8*n_bytes +: 8] <= shreg;
						n_bytes <= n_bytes + 1;
						sda_oe  <= 1'b1;
					end
					default: sda_oe <= 1'b0; // master sends its acknowledge
				endcase
			end else if (bit_cnt == 9) begin
				bit_cnt <= 0;
				sda_oe  <= 1'b0;
				if (phase == PH_ADDR && acked)
					phase <= addr_byte[0] ? PH_READ : PH_WRITE;
				if ((phase == PH_ADDR && acked && addr_byte[0]) ||
						(phase == PH_READ && master_ack)) begin
					if (rd_q.size() == 0) begin
						nb = 8'h00;
						underruns <= underruns + 1;
					end else begin
						nb = rd_q.pop_front();
					end
					shreg  <= nb;
					sda_oe <= ~nb[7]; // first data bit
				end
			end else if (phase == PH_READ && bit_cnt > 0) begin
				sda_oe <= ~shreg[7 - bit_cnt];
			end
		end
	end

endmodule

/* tb_adc_monitor.sv */
`timescale 1ns/10ps
`include "adc_params.svh"

module tb_adc_monitor;
	import adc_pkg::*;

	localparam int CLK_PERIOD = 100;

	logic          clk = 1'b0;
	logic          reset;
	logic          scl_oe, sda_oe, model_sda_oe;
	logic          scl_line, sda_line;
	logic          nack_all;
	sample_idx_t   sample_rd_idx;
	adc_sample_t   sample_rd_data;
	sample_count_t sample_count;
	logic          led1, led2, led3, led4;
	int            seed = 47766;
	int            errors = 0;
	int            checks = 0;
	int            n_samples = 0;
	adc_sample_t   exp_ring [0:`SAMPLE_DEPTH-1];

	assign scl_line = ~scl_oe;                  // only the master drives SCL
	assign sda_line = ~(sda_oe | model_sda_oe); // wired-AND with pull-up

	adc_monitor_top dut (
		.clk(clk), .reset(reset), .scl_in(scl_line), .sda_in(sda_line),
		.sample_rd_idx(sample_rd_idx), .scl_oe(scl_oe), .sda_oe(sda_oe),
		.sample_rd_data(sample_rd_data), .sample_count(sample_count),
		.led1(led1), .led2(led2), .led3(led3), .led4(led4)
	);

	i2c_adc_model adc (
		.clk(clk), .scl(scl_line), .sda(sda_line), .nack_all(nack_all), .sda_oe(model_sda_oe)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic step_clk();
		@(posedge clk);
		#1;
	endtask

	task automatic check_sample(input string name, input adc_sample_t exp, input adc_sample_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAILED %s: expected 0x%04h, actual 0x%04h", name, exp, act);
		end
	endtask

	task automatic check_count(input string name, input sample_count_t exp,
			input sample_count_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAILED %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	task automatic check_byte(input string name, input i2c_byte_t exp, input i2c_byte_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAILED %s: expected 0x%02h, actual 0x%02h", name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAILED %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic expect_leds(input string name, input logic [3:0] exp); // led4..led1
		check_bit({name, " led1"}, exp[0], led1);
		check_bit({name, " led2"}, exp[1], led2);
		check_bit({name, " led3"}, exp[2], led3);
		check_bit({name, " led4"}, exp[3], led4);
	endtask

	task automatic expect_write(input string name, input int idx, input int len,
			input logic [23:0] data);
		i2c_byte_t   a;
		logic        ack;
		int          l;
		logic [23:0] d;
		adc.read_log(idx, a, ack, l, d);
		check_byte({name, " address"}, {`ADC_I2C_ADDR, 1'b0}, a);
		check_bit({name, " ack"}, 1'b1, ack);
		check_byte({name, " length"}, i2c_byte_t'(len), i2c_byte_t'(l));
		for (int k = 0; k < len; k++)
			check_byte($sformatf("%s byte %0d", name, k), data[8*k +: 8], d[8*k +: 8]);
	endtask

	task automatic expect_entry(input string name, input int idx);
		sample_rd_idx = sample_idx_t'(idx);
		#1;
		check_sample($sformatf("%s entry %0d", name, idx), exp_ring[idx], sample_rd_data);
	endtask

	task automatic take_sample(input string name, input adc_sample_t value);
		int reads;
		int exp_count;
		int waited;
		reads = adc.reads_done;
		adc.queue_read(value[15:8]);
		adc.queue_read(value[7:0]);
		while (adc.reads_done == reads)
			step_clk();
		waited = 0;
		while (!dut.sample_valid && waited < 4 * `I2C_QUARTER_DIV) begin
			step_clk();
			waited++;
		end
		if (!dut.sample_valid) begin
			errors++;
			$display("%s: no sample strobe after the read finished", name);
		end
		step_clk(); // count and LEDs follow the strobe
		exp_ring[n_samples % `SAMPLE_DEPTH] = value;
		n_samples++;
		exp_count = (n_samples > `SAMPLE_DEPTH) ? `SAMPLE_DEPTH : n_samples;
		check_count({name, " count"}, sample_count_t'(exp_count), sample_count);
		expect_entry(name, (n_samples - 1) % `SAMPLE_DEPTH);
	endtask

	task automatic reset_values();
		repeat (8) step_clk();
		check_bit("reset scl_oe", 1'b0, scl_oe);
		check_bit("reset sda_oe", 1'b0, sda_oe);
		expect_leds("reset", 4'b0000);
		check_count("reset count", '0, sample_count);
		reset = 1'b0;
	endtask

	task automatic startup_writes();
		while (adc.log_size() < 2)
			step_clk();
		expect_write("config write", 0, 3, 24'h834201);
		expect_write("pointer write", 1, 1, 24'h000000);
	endtask

	task automatic nack_recovery();
		int logged;
		nack_all = 1'b1;
		while (!led4)
			step_clk();
		logged = adc.log_size();
		while (adc.log_size() < logged + 2) // two refused configuration writes
			step_clk();
		check_count("nack count held", sample_count_t'(n_samples), sample_count);
		check_bit("nack led4", 1'b1, led4);
		nack_all = 1'b0;
		logged = adc.log_size();
		while (led4)
			step_clk();
		expect_write("reconfigure", logged, 3, 24'h834201);
		take_sample("resume", adc_sample_t'($random(seed)));
		check_bit("resume led4", 1'b0, led4);
	endtask

	initial begin
		reset = 1'b1;
		nack_all = 1'b0;
		sample_rd_idx = '0;
		reset_values();
		startup_writes();
		for (int i = 0; i < 5; i++)
			take_sample("sampling", adc_sample_t'($random(seed)));
		nack_recovery();
		while (n_samples < 12)
			take_sample("ring wrap", adc_sample_t'($random(seed)));
		for (int i = 0; i < `SAMPLE_DEPTH; i++)
			expect_entry("ring wrap", i);
		take_sample("led high", 16'hC100);
		expect_leds("led high", 4'b0100);
		take_sample("led mid", 16'h9000);
		expect_leds("led mid", 4'b0010);
		take_sample("led low", 16'h1000);
		expect_leds("led low", 4'b0001);
		if (adc.underruns != 0) begin
			errors++;
			$display("the converter model ran out of read data %0d times", adc.underruns);
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	initial begin
		#(40 * `SAMPLE_PERIOD * CLK_PERIOD);
		$display("watchdog expired before the tests finished, %0d errors so far", errors);
		$display("Result: FAILED");
		$finish;
	end

endmodule

/* project.f */
+incdir+.
adc_pkg.sv
i2c_cmd_if.sv
i2c_master.sv
adc_sequencer.sv
adc_sample_regs.sv
adc_monitor_top.sv
i2c_adc_model.sv
tb_adc_monitor.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing -j 0 -Wno-fatal
TOP      = tb_adc_monitor
FILELIST = project.f
OBJ_DIR  = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf $(OBJ_DIR)
